/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_ao_peripheral_subsystem
FILELIST = ao_peripheral_subsystem.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "STATUS: FAIL" $(LOG) || [ $$status -ne 0 ]; then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

/* ao_periph_pkg.sv */
// Always-on peripheral subsystem package
// Address map, register offsets and the shared enums

package ao_periph_pkg;

  localparam int unsigned REG_ADDR_WIDTH = 12;
  localparam int unsigned REG_DATA_WIDTH = 32;

  // Slave select field is address bits 9:8
  localparam int unsigned SLAVE_SEL_LSB = 8;
  localparam int unsigned NUM_SLAVES    = 3;

  typedef enum logic [1:0] {
    SLAVE_SOC_CTRL      = 2'd0,
    SLAVE_POWER_MANAGER = 2'd1,
    SLAVE_TIMER         = 2'd2,
    SLAVE_NONE          = 2'd3
  } slave_e;

  // SoC control registers
  localparam logic [7:0] SOC_EXIT_VALID_OFS  = 8'h00;
  localparam logic [7:0] SOC_EXIT_VALUE_OFS  = 8'h04;
  localparam logic [7:0] SOC_BOOT_SELECT_OFS = 8'h08;

  // Power manager registers
  localparam logic [7:0] PM_WAKEUP_MASK_OFS = 8'h00;
  localparam logic [7:0] PM_SLEEP_EN_OFS    = 8'h04;
  localparam logic [7:0] PM_STATUS_OFS      = 8'h08;

  // Timer registers
  localparam logic [7:0] TMR_CTRL_OFS        = 8'h00;
  localparam logic [7:0] TMR_PRESCALE_OFS    = 8'h04;
  localparam logic [7:0] TMR_COMPARE_OFS     = 8'h08;
  localparam logic [7:0] TMR_COUNT_OFS       = 8'h0C;
  localparam logic [7:0] TMR_INTR_STATUS_OFS = 8'h10;

  // CPU domain states, numbered in sequencing order
  typedef enum logic [2:0] {
    PWR_ACTIVE        = 3'd0,
    PWR_CLK_GATED     = 3'd1,
    PWR_ISOLATED      = 3'd2,
    PWR_RESET         = 3'd3,
    PWR_OFF           = 3'd4,
    PWR_POWER_ON      = 3'd5,
    PWR_RESET_RELEASE = 3'd6,
    PWR_ISO_RELEASE   = 3'd7
  } pwr_state_e;

endpackage : ao_periph_pkg

/* ao_peripheral_subsystem.f */
ao_periph_pkg.sv
ao_reg_demux.sv
ao_soc_ctrl.sv
ao_timer.sv
ao_power_manager.sv
ao_peripheral_subsystem.sv
tb_clk_gen.sv
tb_ao_peripheral_subsystem.sv

/* ao_peripheral_subsystem.sv */
// Always-on peripheral subsystem top
// Register bus demux with SoC control, timer and CPU power manager

`timescale 1ns/10ps

module ao_peripheral_subsystem #(
  parameter int unsigned TIMER_WIDTH = 32,
  parameter int unsigned INTR_WIDTH  = 8
) (
  input  logic                                      clk_i,
  input  logic                                      arst_n_i,
  input  logic                                      reg_valid_i,
  input  logic                                      reg_write_i,
  input  logic [ao_periph_pkg::REG_ADDR_WIDTH-1:0]  reg_addr_i,
  input  logic [ao_periph_pkg::REG_DATA_WIDTH-1:0]  reg_wdata_i,
  output logic [ao_periph_pkg::REG_DATA_WIDTH-1:0]  reg_rdata_o,
  output logic                                      reg_ready_o,
  output logic                                      reg_error_o,
  input  logic                                      boot_select_i,
  input  logic                                      core_sleep_i,
  input  logic [INTR_WIDTH-2:0]                     intr_i,
  output logic                                      exit_valid_o,
  output logic [31:0]                               exit_value_o,
  output logic                                      timer_intr_o,
  output logic                                      cpu_clk_en_o,
  output logic                                      cpu_iso_o,
  output logic                                      cpu_rst_n_o,
  output logic                                      cpu_pwr_off_o
);
  import ao_periph_pkg::*;

  logic                      soc_valid;
  logic                      pm_valid;
  logic                      tmr_valid;
  logic                      slv_write;
  logic [7:0]                slv_offset;
  logic [REG_DATA_WIDTH-1:0] slv_wdata;
  logic [REG_DATA_WIDTH-1:0] soc_rdata;
  logic [REG_DATA_WIDTH-1:0] pm_rdata;
  logic [REG_DATA_WIDTH-1:0] tmr_rdata;

  ao_reg_demux i_ao_reg_demux (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .reg_valid_i  (reg_valid_i),
    .reg_write_i  (reg_write_i),
    .reg_addr_i   (reg_addr_i),
    .reg_wdata_i  (reg_wdata_i),
    .reg_rdata_o  (reg_rdata_o),
    .reg_ready_o  (reg_ready_o),
    .reg_error_o  (reg_error_o),
    .soc_valid_o  (soc_valid),
    .pm_valid_o   (pm_valid),
    .tmr_valid_o  (tmr_valid),
    .slv_write_o  (slv_write),
    .slv_offset_o (slv_offset),
    .slv_wdata_o  (slv_wdata),
    .soc_rdata_i  (soc_rdata),
    .pm_rdata_i   (pm_rdata),
    .tmr_rdata_i  (tmr_rdata)
  );

  ao_soc_ctrl i_ao_soc_ctrl (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .valid_i       (soc_valid),
    .write_i       (slv_write),
    .offset_i      (slv_offset),
    .wdata_i       (slv_wdata),
    .rdata_o       (soc_rdata),
    .boot_select_i (boot_select_i),
    .exit_valid_o  (exit_valid_o),
    .exit_value_o  (exit_value_o)
  );

  ao_timer #(
    .TIMER_WIDTH (TIMER_WIDTH)
  ) i_ao_timer (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .valid_i      (tmr_valid),
    .write_i      (slv_write),
    .offset_i     (slv_offset),
    .wdata_i      (slv_wdata),
    .rdata_o      (tmr_rdata),
    .timer_intr_o (timer_intr_o)
  );

  // Timer interrupt is wake bit 0, external lines above it
  ao_power_manager #(
    .INTR_WIDTH (INTR_WIDTH)
  ) i_ao_power_manager (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .valid_i       (pm_valid),
    .write_i       (slv_write),
    .offset_i      (slv_offset),
    .wdata_i       (slv_wdata),
    .rdata_o       (pm_rdata),
    .intr_i        ({intr_i, timer_intr_o}),
    .core_sleep_i  (core_sleep_i),
    .cpu_clk_en_o  (cpu_clk_en_o),
    .cpu_iso_o     (cpu_iso_o),
    .cpu_rst_n_o   (cpu_rst_n_o),
    .cpu_pwr_off_o (cpu_pwr_off_o)
  );

endmodule : ao_peripheral_subsystem

/* ao_power_manager.sv */
// CPU domain power manager
// Steps the domain down on sleep and back up on an unmasked wake interrupt

`timescale 1ns/10ps

module ao_power_manager #(
  parameter int unsigned INTR_WIDTH = 8
) (
  input  logic                                      clk_i,
  input  logic                                      arst_n_i,
  input  logic                                      valid_i,
  input  logic                                      write_i,
  input  logic [7:0]                                offset_i,
  input  logic [ao_periph_pkg::REG_DATA_WIDTH-1:0]  wdata_i,
  output logic [ao_periph_pkg::REG_DATA_WIDTH-1:0]  rdata_o,
  input  logic [INTR_WIDTH-1:0]                     intr_i,
  input  logic                                      core_sleep_i,
  output logic                                      cpu_clk_en_o,
  output logic                                      cpu_iso_o,
  output logic                                      cpu_rst_n_o,
  output logic                                      cpu_pwr_off_o
);
  import ao_periph_pkg::*;

  pwr_state_e            state_q;
  pwr_state_e            state_d;
  logic [INTR_WIDTH-1:0] wakeup_mask_q;
  logic                  sleep_en_q;
  logic                  wr_en;
  logic                  wake;

  assign wr_en = valid_i && write_i;
  assign wake  = |(intr_i & wakeup_mask_q);

  always_comb begin
    state_d = state_q;
    case (state_q)
      PWR_ACTIVE:        if (sleep_en_q && core_sleep_i) state_d = PWR_CLK_GATED;
      PWR_CLK_GATED:     state_d = PWR_ISOLATED;
      PWR_ISOLATED:      state_d = PWR_RESET;
      PWR_RESET:         state_d = PWR_OFF;
      PWR_OFF:           if (wake) state_d = PWR_POWER_ON;
      PWR_POWER_ON:      state_d = PWR_RESET_RELEASE;
      PWR_RESET_RELEASE: state_d = PWR_ISO_RELEASE;
      PWR_ISO_RELEASE:   state_d = PWR_ACTIVE;
      default:           state_d = PWR_ACTIVE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q       <= PWR_ACTIVE;
      wakeup_mask_q <= '0;
      sleep_en_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      if (wr_en && offset_i == PM_WAKEUP_MASK_OFS) wakeup_mask_q <= wdata_i[INTR_WIDTH-1:0];
      // Sleep arm is one-shot, dropped as the sequence starts
      if (state_d == PWR_CLK_GATED) begin
        sleep_en_q <= 1'b0;
      end else if (wr_en && offset_i == PM_SLEEP_EN_OFS) begin
        sleep_en_q <= wdata_i[0];
      end
    end
  end

  always_comb begin
    rdata_o = '0;
    case (offset_i)
      PM_WAKEUP_MASK_OFS: rdata_o[INTR_WIDTH-1:0] = wakeup_mask_q;
      PM_SLEEP_EN_OFS:    rdata_o[0]              = sleep_en_q;
      PM_STATUS_OFS:      rdata_o[2:0]            = state_q;
      default:            rdata_o                 = '0;
    endcase
  end

  // Domain controls held between the state that sets and the one that clears them
  assign cpu_clk_en_o  = (state_q == PWR_ACTIVE);
  assign cpu_iso_o     = !(state_q inside {PWR_ACTIVE, PWR_CLK_GATED, PWR_ISO_RELEASE});
  assign cpu_rst_n_o   = !(state_q inside {PWR_RESET, PWR_OFF, PWR_POWER_ON});
  assign cpu_pwr_off_o = (state_q == PWR_OFF);

  a_off_is_safe: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    cpu_pwr_off_o |-> (cpu_iso_o && !cpu_rst_n_o));

  // Hold or advance by one, wrapping ISO_RELEASE back to ACTIVE
  a_legal_step: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (state_q == $past(state_q)) || (state_q == $past(3'(state_q + 3'd1))));

endmodule : ao_power_manager

/* ao_reg_demux.sv */
// Register bus demux for the always-on slaves
// Decodes the slave field, steers the strobe and returns data or an error

`timescale 1ns/10ps

module ao_reg_demux (
  input  logic                                      clk_i,
  input  logic                                      arst_n_i,
  input  logic                                      reg_valid_i,
  input  logic                                      reg_write_i,
  input  logic [ao_periph_pkg::REG_ADDR_WIDTH-1:0]  reg_addr_i,
  input  logic [ao_periph_pkg::REG_DATA_WIDTH-1:0]  reg_wdata_i,
  output logic [ao_periph_pkg::REG_DATA_WIDTH-1:0]  reg_rdata_o,
  output logic                                      reg_ready_o,
  output logic                                      reg_error_o,
  output logic                                      soc_valid_o,
  output logic                                      pm_valid_o,
  output logic                                      tmr_valid_o,
  output logic                                      slv_write_o,
  output logic [7:0]                                slv_offset_o,
  output logic [ao_periph_pkg::REG_DATA_WIDTH-1:0]  slv_wdata_o,
  input  logic [ao_periph_pkg::REG_DATA_WIDTH-1:0]  soc_rdata_i,
  input  logic [ao_periph_pkg::REG_DATA_WIDTH-1:0]  pm_rdata_i,
  input  logic [ao_periph_pkg::REG_DATA_WIDTH-1:0]  tmr_rdata_i
);
  import ao_periph_pkg::*;

  slave_e                sel;
  logic                  upper_set;
  logic [NUM_SLAVES-1:0] slv_valid;

  assign sel = slave_e'(reg_addr_i[SLAVE_SEL_LSB +: 2]);
  // Bits above the select field are not decoded, so any of them set is unmapped
  assign upper_set = |reg_addr_i[REG_ADDR_WIDTH-1:SLAVE_SEL_LSB+2];

  always_comb begin
    slv_valid   = '0;
    reg_rdata_o = '0;
    reg_error_o = 1'b0;
    if (reg_valid_i) begin
      if (upper_set) begin
        reg_error_o = 1'b1;
      end else begin
        case (sel)
          SLAVE_SOC_CTRL: begin
            slv_valid[SLAVE_SOC_CTRL] = 1'b1;
            reg_rdata_o               = soc_rdata_i;
          end
          SLAVE_POWER_MANAGER: begin
            slv_valid[SLAVE_POWER_MANAGER] = 1'b1;
            reg_rdata_o                    = pm_rdata_i;
          end
          SLAVE_TIMER: begin
            slv_valid[SLAVE_TIMER] = 1'b1;
            reg_rdata_o            = tmr_rdata_i;
          end
          // SLAVE_NONE
          default: reg_error_o = 1'b1;
        endcase
      end
    end
  end

  // No back-pressure
  assign reg_ready_o = reg_valid_i;

  assign soc_valid_o  = slv_valid[SLAVE_SOC_CTRL];
  assign pm_valid_o   = slv_valid[SLAVE_POWER_MANAGER];
  assign tmr_valid_o  = slv_valid[SLAVE_TIMER];
  assign slv_write_o  = reg_write_i;
  assign slv_offset_o = reg_addr_i[SLAVE_SEL_LSB-1:0];
  assign slv_wdata_o  = reg_wdata_i;

  // At most one slave strobed, never alongside an error
  a_one_slave: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(slv_valid) && !(reg_error_o && |slv_valid));

endmodule : ao_reg_demux

/* ao_soc_ctrl.sv */
// SoC control block
// Exit value and exit-valid registers, boot-select pin readback

`timescale 1ns/10ps

module ao_soc_ctrl (
  input  logic                                      clk_i,
  input  logic                                      arst_n_i,
  input  logic                                      valid_i,
  input  logic                                      write_i,
  input  logic [7:0]                                offset_i,
  input  logic [ao_periph_pkg::REG_DATA_WIDTH-1:0]  wdata_i,
  output logic [ao_periph_pkg::REG_DATA_WIDTH-1:0]  rdata_o,
  input  logic                                      boot_select_i,
  output logic                                      exit_valid_o,
  output logic [31:0]                               exit_value_o
);
  import ao_periph_pkg::*;

  logic        exit_valid_q;
  logic [31:0] exit_value_q;
  logic        wr_en;

  assign wr_en = valid_i && write_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
    end else begin
      if (wr_en && offset_i == SOC_EXIT_VALID_OFS) exit_valid_q <= wdata_i[0];
      if (wr_en && offset_i == SOC_EXIT_VALUE_OFS) exit_value_q <= wdata_i;
    end
  end

  always_comb begin
    rdata_o = '0;
    case (offset_i)
      SOC_EXIT_VALID_OFS:  rdata_o[0] = exit_valid_q;
      SOC_EXIT_VALUE_OFS:  rdata_o    = exit_value_q;
      SOC_BOOT_SELECT_OFS: rdata_o[0] = boot_select_i;
      default:             rdata_o    = '0;
    endcase
  end

  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

  // Register contents only move after a bus write
  a_write_only_on_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ($changed(exit_value_q) || $changed(exit_valid_q)) |-> $past(valid_i && write_i));

endmodule : ao_soc_ctrl

/* ao_timer.sv */
// Always-on prescaled timer
// Counter with compare, sticky interrupt status and register access

`timescale 1ns/10ps

module ao_timer #(
  parameter int unsigned TIMER_WIDTH = 32
) (
  input  logic                                      clk_i,
  input  logic                                      arst_n_i,
  input  logic                                      valid_i,
  input  logic                                      write_i,
  input  logic [7:0]                                offset_i,
  input  logic [ao_periph_pkg::REG_DATA_WIDTH-1:0]  wdata_i,
  output logic [ao_periph_pkg::REG_DATA_WIDTH-1:0]  rdata_o,
  output logic                                      timer_intr_o
);
  import ao_periph_pkg::*;

  logic                   enable_q;
  logic [TIMER_WIDTH-1:0] prescale_q;
  logic [TIMER_WIDTH-1:0] compare_q;
  logic [TIMER_WIDTH-1:0] count_q;
  logic [TIMER_WIDTH-1:0] tick_q;
  logic                   intr_status_q;
  logic                   wr_en;
  logic                   tick_wrap;
  logic                   cmp_hit;

  assign wr_en     = valid_i && write_i;
  assign tick_wrap = (tick_q == prescale_q);
  // Compare only counts while the timer runs
  assign cmp_hit   = enable_q && (count_q >= compare_q);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      enable_q      <= 1'b0;
      prescale_q    <= '0;
      compare_q     <= '0;
      count_q       <= '0;
      tick_q        <= '0;
      intr_status_q <= 1'b0;
    end else begin
      if (wr_en && offset_i == TMR_CTRL_OFS) enable_q <= wdata_i[0];
      if (wr_en && offset_i == TMR_COMPARE_OFS) compare_q <= wdata_i[TIMER_WIDTH-1:0];

      // New prescale restarts the tick
      if (wr_en && offset_i == TMR_PRESCALE_OFS) begin
        prescale_q <= wdata_i[TIMER_WIDTH-1:0];
        tick_q     <= '0;
      end else if (enable_q) begin
        tick_q <= tick_wrap ? '0 : tick_q + 1'b1;
      end

      if (wr_en && offset_i == TMR_COUNT_OFS) begin
        count_q <= wdata_i[TIMER_WIDTH-1:0];
      end else if (enable_q && tick_wrap) begin
        count_q <= count_q + 1'b1;
      end

      // W1C wins, a still-true compare sets it again next cycle
      if (wr_en && offset_i == TMR_INTR_STATUS_OFS && wdata_i[0]) begin
        intr_status_q <= 1'b0;
      end else if (cmp_hit) begin
        intr_status_q <= 1'b1;
      end
    end
  end

  always_comb begin
    rdata_o = '0;
    case (offset_i)
      TMR_CTRL_OFS:        rdata_o[0]               = enable_q;
      TMR_PRESCALE_OFS:    rdata_o[TIMER_WIDTH-1:0] = prescale_q;
      TMR_COMPARE_OFS:     rdata_o[TIMER_WIDTH-1:0] = compare_q;
      TMR_COUNT_OFS:       rdata_o[TIMER_WIDTH-1:0] = count_q;
      TMR_INTR_STATUS_OFS: rdata_o[0]               = intr_status_q;
      default:             rdata_o                  = '0;
    endcase
  end

  assign timer_intr_o = intr_status_q;

  a_tick_in_range: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    tick_q <= prescale_q);

endmodule : ao_timer

/* tb_ao_peripheral_subsystem.sv */
// Testbench for the always-on peripheral subsystem
// Runs a table of bus accesses and pin steps against the DUT

`timescale 1ns/10ps

module tb_ao_peripheral_subsystem;
  import ao_periph_pkg::*;

  localparam int unsigned TIMER_WIDTH = 32;
  localparam int unsigned INTR_WIDTH  = 8;

  typedef enum int {OP_WRITE, OP_READ, OP_READ_MIN, OP_SET_PIN, OP_CHK_PIN, OP_WAIT_PIN} op_e;
  typedef enum int {
    PIN_BOOT_SELECT, PIN_CORE_SLEEP, PIN_INTR, PIN_EXIT_VALID, PIN_EXIT_VALUE,
    PIN_TIMER_INTR, PIN_CLK_EN, PIN_ISO, PIN_RST_N, PIN_PWR_OFF
  } pin_e;

  // target is a bus address or a pin, data is write data or a wait limit
  typedef struct {
    int          test;
    op_e         op;
    int unsigned target;
    logic [31:0] data;
    logic [31:0] exp;
    logic        err;
  } step_t;

  logic                  clk;
  logic                  arst_n;
  logic                  reg_valid_i;
  logic                  reg_write_i;
  logic [11:0]           reg_addr_i;
  logic [31:0]           reg_wdata_i;
  logic [31:0]           reg_rdata_o;
  logic                  reg_ready_o;
  logic                  reg_error_o;
  logic                  boot_select_i;
  logic                  core_sleep_i;
  logic [INTR_WIDTH-2:0] intr_i;
  logic                  exit_valid_o;
  logic [31:0]           exit_value_o;
  logic                  timer_intr_o;
  logic                  cpu_clk_en_o;
  logic                  cpu_iso_o;
  logic                  cpu_rst_n_o;
  logic                  cpu_pwr_off_o;

  step_t       steps[$];
  integer      seed;
  logic [31:0] exit_val;
  int          test_errors;
  int          total_errors;
  int          tests_failed;
  int          tests_run;

  tb_clk_gen #(.CLK_PERIOD(100), .RST_CYCLES(10)) i_tb_clk_gen (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  ao_peripheral_subsystem #(
    .TIMER_WIDTH (TIMER_WIDTH),
    .INTR_WIDTH  (INTR_WIDTH)
  ) i_ao_peripheral_subsystem (
    .clk_i         (clk),
    .arst_n_i      (arst_n),
    .reg_valid_i   (reg_valid_i),
    .reg_write_i   (reg_write_i),
    .reg_addr_i    (reg_addr_i),
    .reg_wdata_i   (reg_wdata_i),
    .reg_rdata_o   (reg_rdata_o),
    .reg_ready_o   (reg_ready_o),
    .reg_error_o   (reg_error_o),
    .boot_select_i (boot_select_i),
    .core_sleep_i  (core_sleep_i),
    .intr_i        (intr_i),
    .exit_valid_o  (exit_valid_o),
    .exit_value_o  (exit_value_o),
    .timer_intr_o  (timer_intr_o),
    .cpu_clk_en_o  (cpu_clk_en_o),
    .cpu_iso_o     (cpu_iso_o),
    .cpu_rst_n_o   (cpu_rst_n_o),
    .cpu_pwr_off_o (cpu_pwr_off_o)
  );

  function automatic string pin_name(input int unsigned pin);
    case (pin)
      PIN_BOOT_SELECT: return "boot_select_i";
      PIN_CORE_SLEEP:  return "core_sleep_i";
      PIN_INTR:        return "intr_i";
      PIN_EXIT_VALID:  return "exit_valid_o";
      PIN_EXIT_VALUE:  return "exit_value_o";
      PIN_TIMER_INTR:  return "timer_intr_o";
      PIN_CLK_EN:      return "cpu_clk_en_o";
      PIN_ISO:         return "cpu_iso_o";
      PIN_RST_N:       return "cpu_rst_n_o";
      PIN_PWR_OFF:     return "cpu_pwr_off_o";
      default:         return "unknown pin";
    endcase
  endfunction

  function automatic logic [31:0] pin_value(input int unsigned pin);
    case (pin)
      PIN_EXIT_VALID: return 32'(exit_valid_o);
      PIN_EXIT_VALUE: return exit_value_o;
      PIN_TIMER_INTR: return 32'(timer_intr_o);
      PIN_CLK_EN:     return 32'(cpu_clk_en_o);
      PIN_ISO:        return 32'(cpu_iso_o);
      PIN_RST_N:      return 32'(cpu_rst_n_o);
      PIN_PWR_OFF:    return 32'(cpu_pwr_off_o);
      default:        return 32'hdead_beef;
    endcase
  endfunction

  function automatic string test_name(input int test);
    case (test)
      1:       return "reset values";
      2:       return "soc control";
      3:       return "address decode";
      4:       return "timer";
      5:       return "sleep";
      6:       return "wake";
      default: return "unnamed";
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp, input bit at_least);
    bit ok;
    ok = at_least ? (got >= exp) : (got === exp);
    if (!ok) begin
      $display("Fail %s: got 0x%08h, expected %s0x%08h", name, got,
               at_least ? ">= " : "", exp);
      test_errors++;
    end
  endtask

  // One access lasts a single valid cycle, response sampled mid cycle
  task automatic bus_access(input step_t s);
    @(posedge clk);
    reg_valid_i <= 1'b1;
    reg_write_i <= (s.op == OP_WRITE);
    reg_addr_i  <= 12'(s.target);
    reg_wdata_i <= s.data;
    @(negedge clk);
    check_value("reg_ready_o", 32'(reg_ready_o), 32'd1, 1'b0);
    check_value("reg_error_o", 32'(reg_error_o), 32'(s.err), 1'b0);
    if (s.op != OP_WRITE) begin
      check_value("reg_rdata_o", reg_rdata_o, s.exp, s.op == OP_READ_MIN);
    end
    @(posedge clk);
    reg_valid_i <= 1'b0;
    reg_write_i <= 1'b0;
  endtask

  task automatic set_pin(input int unsigned pin, input logic [31:0] value);
    @(posedge clk);
    case (pin)
      PIN_BOOT_SELECT: boot_select_i <= value[0];
      PIN_CORE_SLEEP:  core_sleep_i  <= value[0];
      PIN_INTR:        intr_i        <= value[INTR_WIDTH-2:0];
      default: begin
        $display("Step error: %s cannot be driven", pin_name(pin));
        test_errors++;
      end
    endcase
  endtask

  task automatic wait_pin(input int unsigned pin, input logic [31:0] exp,
                          input int unsigned limit);
    int unsigned cycles;
    bit          seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < limit) begin
      @(negedge clk);
      cycles++;
      seen = (pin_value(pin) === exp);
    end
    if (!seen) begin
      $display("Timeout: %s did not reach 0x%0h within %0d cycles", pin_name(pin), exp, limit);
      test_errors++;
    end
  endtask

  task automatic run_step(input step_t s);
    case (s.op)
      OP_WRITE, OP_READ, OP_READ_MIN: bus_access(s);
      OP_SET_PIN:  set_pin(s.target, s.data);
      OP_WAIT_PIN: wait_pin(s.target, s.exp, s.data);
      default: begin
        @(negedge clk);
        check_value(pin_name(s.target), pin_value(s.target), s.exp, 1'b0);
      end
    endcase
  endtask

  task automatic report_test(input int test);
    tests_run++;
    if (test_errors == 0) begin
      $display("Test %0d %s: passed", test, test_name(test));
    end else begin
      $display("Test %0d %s: failed with %0d errors", test, test_name(test), test_errors);
      tests_failed++;
    end
    total_errors += test_errors;
    test_errors = 0;
  endtask

  task automatic add(input int test, input op_e op, input int unsigned target,
                     input logic [31:0] data, input logic [31:0] exp, input logic err);
    step_t s;
    s = '{test, op, target, data, exp, err};
    steps.push_back(s);
  endtask

  task automatic build_table();
    // Reset values
    add(1, OP_CHK_PIN, PIN_CLK_EN, 0, 1, 0);
    add(1, OP_CHK_PIN, PIN_ISO, 0, 0, 0);
    add(1, OP_CHK_PIN, PIN_RST_N, 0, 1, 0);
    add(1, OP_CHK_PIN, PIN_PWR_OFF, 0, 0, 0);
    add(1, OP_CHK_PIN, PIN_EXIT_VALID, 0, 0, 0);
    add(1, OP_CHK_PIN, PIN_EXIT_VALUE, 0, 0, 0);
    add(1, OP_CHK_PIN, PIN_TIMER_INTR, 0, 0, 0);
    add(1, OP_READ, 'h108, 0, 32'(PWR_ACTIVE), 0);
    // SoC control
    add(2, OP_WRITE, 'h004, exit_val, 0, 0);
    add(2, OP_CHK_PIN, PIN_EXIT_VALUE, 0, exit_val, 0);
    add(2, OP_READ, 'h004, 0, exit_val, 0);
    add(2, OP_WRITE, 'h000, 1, 0, 0);
    add(2, OP_CHK_PIN, PIN_EXIT_VALID, 0, 1, 0);
    add(2, OP_READ, 'h000, 0, 1, 0);
    add(2, OP_SET_PIN, PIN_BOOT_SELECT, 1, 0, 0);
    add(2, OP_READ, 'h008, 0, 1, 0);
    add(2, OP_SET_PIN, PIN_BOOT_SELECT, 0, 0, 0);
    add(2, OP_READ, 'h008, 0, 0, 0);
    // Decode, unmapped window and unused offsets
    add(3, OP_READ, 'h300, 0, 0, 1);
    add(3, OP_WRITE, 'h304, 32'hffff_ffff, 0, 1);
    add(3, OP_READ, 'h30c, 0, 0, 1);
    add(3, OP_READ, 'h004, 0, exit_val, 0);
    add(3, OP_READ, 'h00c, 0, 0, 0);
    add(3, OP_READ, 'h10c, 0, 0, 0);
    add(3, OP_READ, 'h214, 0, 0, 0);
    // Timer
    add(4, OP_WRITE, 'h204, 3, 0, 0);
    add(4, OP_WRITE, 'h208, 5, 0, 0);
    add(4, OP_WRITE, 'h200, 1, 0, 0);
    add(4, OP_WAIT_PIN, PIN_TIMER_INTR, 100, 1, 0);
    add(4, OP_READ_MIN, 'h20c, 0, 5, 0);
    add(4, OP_WRITE, 'h200, 0, 0, 0);
    add(4, OP_WRITE, 'h210, 1, 0, 0);
    add(4, OP_CHK_PIN, PIN_TIMER_INTR, 0, 0, 0);
    add(4, OP_READ, 'h210, 0, 0, 0);
    // Sleep with only wake bit 2 unmasked
    add(5, OP_WRITE, 'h100, 32'h4, 0, 0);
    add(5, OP_WRITE, 'h104, 1, 0, 0);
    add(5, OP_READ, 'h104, 0, 1, 0);
    add(5, OP_SET_PIN, PIN_CORE_SLEEP, 1, 0, 0);
    add(5, OP_WAIT_PIN, PIN_PWR_OFF, 20, 1, 0);
    add(5, OP_CHK_PIN, PIN_ISO, 0, 1, 0);
    add(5, OP_CHK_PIN, PIN_RST_N, 0, 0, 0);
    add(5, OP_CHK_PIN, PIN_CLK_EN, 0, 0, 0);
    add(5, OP_READ, 'h108, 0, 32'(PWR_OFF), 0);
    add(5, OP_READ, 'h104, 0, 0, 0);
    // Wake, masked pulse first
    add(6, OP_SET_PIN, PIN_INTR, 32'h1, 0, 0);
    add(6, OP_SET_PIN, PIN_INTR, 32'h0, 0, 0);
    add(6, OP_READ, 'h108, 0, 32'(PWR_OFF), 0);
    add(6, OP_CHK_PIN, PIN_PWR_OFF, 0, 1, 0);
    add(6, OP_SET_PIN, PIN_INTR, 32'h2, 0, 0);
    add(6, OP_SET_PIN, PIN_CORE_SLEEP, 0, 0, 0);
    add(6, OP_SET_PIN, PIN_INTR, 32'h0, 0, 0);
    add(6, OP_WAIT_PIN, PIN_CLK_EN, 20, 1, 0);
    add(6, OP_CHK_PIN, PIN_ISO, 0, 0, 0);
    add(6, OP_CHK_PIN, PIN_RST_N, 0, 1, 0);
    add(6, OP_CHK_PIN, PIN_PWR_OFF, 0, 0, 0);
    add(6, OP_READ, 'h108, 0, 32'(PWR_ACTIVE), 0);
  endtask

  initial begin
    int          cur_test;
    int unsigned rst_cycles;
    reg_valid_i   <= 1'b0;
    reg_write_i   <= 1'b0;
    reg_addr_i    <= '0;
    reg_wdata_i   <= '0;
    boot_select_i <= 1'b0;
    core_sleep_i  <= 1'b0;
    intr_i        <= '0;
    test_errors   = 0;
    total_errors  = 0;
    tests_failed  = 0;
    tests_run     = 0;
    seed          = 32'hdaaf;
    exit_val      = $random(seed);
    build_table();

    rst_cycles = 0;
    while (arst_n !== 1'b1 && rst_cycles < 20) begin
      @(posedge clk);
      rst_cycles++;
    end

    if (arst_n !== 1'b1) begin
      $display("Reset was never released, no test was run");
      total_errors++;
    end else begin
      cur_test = steps[0].test;
      foreach (steps[i]) begin
        if (steps[i].test != cur_test) begin
          report_test(cur_test);
          cur_test = steps[i].test;
        end
        run_step(steps[i]);
      end
      report_test(cur_test);
    end

    $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
             tests_run, tests_run - tests_failed, tests_failed, total_errors);
    if (total_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule : tb_ao_peripheral_subsystem

/* tb_clk_gen.sv */
// Testbench clock and reset generator
// Free running clock, reset held low for a fixed number of cycles

`timescale 1ns/10ps

module tb_clk_gen #(
  parameter int unsigned CLK_PERIOD = 100,
  parameter int unsigned RST_CYCLES = 10
) (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(CLK_PERIOD / 2) clk_o = ~clk_o;
  end

  initial begin
    arst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    arst_n_o <= 1'b1;
  end

endmodule : tb_clk_gen
